//--- Makefile
TOP  := vector_decode_stage_tb
SRCS := $(shell grep -v '^+' project.f)
BIN  := obj_dir/V$(TOP)

.PHONY: run clean

run: $(BIN)
	$(BIN) | tee sim.log
	grep -qx "Everything OK" sim.log

$(BIN): project.f $(SRCS) design/vdec_consts.svh
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir sim.log

//--- design/element_issue.sv
// vl and vstart are read live each cycle and must stay steady while an instruction is in flight
`timescale 1ns/1ps
`include "vdec_consts.svh"

module element_issue (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  occupied,
  input  logic                  stall,
  input  logic                  flush,
  input  vdec_pkg::vctrl_t      cur_ctrl,
  input  logic [4:0]            cur_vd,
  input  logic [2:0]            field,
  input  logic [`OFFSET_W-1:0]  vstart,
  input  logic [`OFFSET_W-1:0]  vl,
  output logic                  field_done,
  output vdec_pkg::dec_ex_t     dec_ex
);

  logic [`OFFSET_W-1:0] idx;
  logic [`OFFSET_W-1:0] uimm, rs1_off;
  logic [`OFFSET_W-1:0] vs2_base, vd_base;
  logic [`OFFSET_W:0]   idx_p1, idx_p2, vl_ext;
  logic last_pair, last_field, scalar_src;
  logic lane0_live, lane1_live, wen_ok;
  vdec_pkg::dec_ex_t next_rec;

  assign uimm    = {{(`OFFSET_W-5){1'b0}}, cur_ctrl.imm5};
  assign rs1_off = cur_ctrl.xs1[`OFFSET_W-1:0];

  // one bit of headroom so the compare survives field_vl near the top
  assign idx_p1 = {1'b0, idx} + 1'b1;
  assign idx_p2 = {1'b0, idx} + 2'd2;
  assign vl_ext = {1'b0, cur_ctrl.field_vl};

  assign last_pair  = idx_p2 >= vl_ext;
  assign last_field = field == cur_ctrl.nf;
  assign field_done = occupied & ~stall & last_pair;

  // pair index, 0, 2, 4 ... within the current field
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      idx <= '0;
    end else if (flush) begin
      idx <= '0;
    end else if (occupied && !stall) begin
      if (last_pair) begin
        idx <= '0;
      end else begin
        idx <= idx_p2[`OFFSET_W-1:0];
      end
    end
  end

  always_comb begin
    case (cur_ctrl.vs2_src)
      vdec_pkg::VS2_IDX_PLUS_RS1:  vs2_base = idx + rs1_off;
      vdec_pkg::VS2_IDX_PLUS_UIMM: vs2_base = idx + uimm;
      vdec_pkg::VS2_IDX_PLUS_1:    vs2_base = idx + 1'b1;
      vdec_pkg::VS2_IDX_MINUS_1:   vs2_base = idx - 1'b1;
      vdec_pkg::VS2_RS1:           vs2_base = rs1_off;
      vdec_pkg::VS2_UIMM:          vs2_base = uimm;
      default:                     vs2_base = idx;
    endcase
  end

  always_comb begin
    case (cur_ctrl.vd_src)
      vdec_pkg::VD_IDX_PLUS_RS1:  vd_base = idx + rs1_off;
      vdec_pkg::VD_IDX_PLUS_UIMM: vd_base = idx + uimm;
      default:                    vd_base = idx;
    endcase
  end

  // gather from a scalar index reads the same element on both lanes
  assign scalar_src = cur_ctrl.vs2_src inside {vdec_pkg::VS2_RS1, vdec_pkg::VS2_UIMM};

  assign lane0_live = {1'b0, idx} < vl_ext;
  assign lane1_live = idx_p1 < vl_ext;
  assign wen_ok     = occupied & (vstart < vl) & ~cur_ctrl.is_store;

  always_comb begin
    next_rec             = '0;
    next_rec.valid       = occupied;
    next_rec.is_load     = cur_ctrl.is_load;
    next_rec.is_store    = cur_ctrl.is_store;
    next_rec.vd          = cur_vd;
    next_rec.field       = field;
    next_rec.eff_sew     = cur_ctrl.eff_sew;
    next_rec.woffset0    = vd_base;
    next_rec.woffset1    = vd_base + 1'b1;
    next_rec.vs2_offset0 = vs2_base;
    next_rec.vs2_offset1 = scalar_src ? vs2_base : vs2_base + 1'b1;
    next_rec.wen[0]      = wen_ok & lane0_live;
    next_rec.wen[1]      = wen_ok & lane1_live;
    next_rec.last        = field_done & last_field;
  end

  // decode/execute record
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dec_ex <= '0;
    end else if (flush) begin
      dec_ex <= '0;
    end else if (!stall) begin
      dec_ex <= next_rec;
    end
  end

endmodule

//--- design/segment_field_buffer.sv
// holds one instruction at a time; accept must only be raised while occupied is low
`timescale 1ns/1ps

module segment_field_buffer (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              accept,
  input  logic              flush,
  input  logic              stall,
  input  logic              field_done,
  input  vdec_pkg::vctrl_t  ctrl,
  output vdec_pkg::vctrl_t  cur_ctrl,
  output logic [4:0]        cur_vd,
  output logic [2:0]        field,
  output logic              occupied
);

  logic field_step, last_field;
  logic [6:0] vd_step;

  assign field_step = field_done & ~stall;
  assign last_field = field == cur_ctrl.nf;

  // held decode of the accepted instruction
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cur_ctrl <= '0;
    end else if (accept) begin
      cur_ctrl <= ctrl;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      occupied <= 1'b0;
    end else if (flush) begin
      occupied <= 1'b0;
    end else if (accept) begin
      occupied <= 1'b1;
    end else if (field_step && last_field) begin
      occupied <= 1'b0;
    end
  end

  // segment field counter, wraps back to 0 after field nf
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      field <= '0;
    end else if (flush) begin
      field <= '0;
    end else if (field_step) begin
      if (last_field) begin
        field <= '0;
      end else begin
        field <= field + 3'd1;
      end
    end
  end

  // each field lands emul_regs registers past the previous one
  assign vd_step = field * cur_ctrl.emul_regs;
  assign cur_vd  = cur_ctrl.vd + vd_step[4:0];

endmodule

//--- design/vdec_consts.svh
// VLEN is fixed at 128 bits and offsets are 8 bits wide, so vl, vstart and offsets wrap past 255
`ifndef VDEC_CONSTS_SVH
`define VDEC_CONSTS_SVH

// vector register geometry
`define VLEN      128
`define VLENB     (`VLEN / 8)
`define OFFSET_W  8

// major opcodes
`define OPC_VLOAD   7'b0000111
`define OPC_VSTORE  7'b0100111
`define OPC_OPV     7'b1010111

// OP-V funct3 categories
`define F3_OPIVV  3'b000
`define F3_OPIVX  3'b100
`define F3_OPIVI  3'b011
`define F3_OPMVX  3'b110

// funct6 codes handled by the offset logic
`define F6_VADD       6'b000000
`define F6_VRGATHER   6'b001100
`define F6_VSLIDEUP   6'b001110
`define F6_VSLIDEDOWN 6'b001111

// lumop/sumop value for whole-register moves
`define LUMOP_WHOLE  5'b01000

`endif

//--- design/vdec_pkg.sv
// decode stage types; SEW and EEW stop at 32 bits and LMUL of one eighth is not supported
`include "vdec_consts.svh"

package vdec_pkg;

  // code equals log2(width / 8)
  typedef enum logic [1:0] {
    SEW8  = 2'b00,
    SEW16 = 2'b01,
    SEW32 = 2'b10
  } sew_t;

  // standard vlmul encoding, two's complement of log2(LMUL)
  typedef enum logic [2:0] {
    LMUL1      = 3'b000,
    LMUL2      = 3'b001,
    LMUL4      = 3'b010,
    LMUL8      = 3'b011,
    LMULFOURTH = 3'b110,
    LMULHALF   = 3'b111
  } vlmul_t;

  typedef enum logic [2:0] {
    WIDTH8  = 3'b000,
    WIDTH16 = 3'b101,
    WIDTH32 = 3'b110
  } width_t;

  typedef struct packed {
    sew_t   sew;
    vlmul_t lmul;
  } vtype_t;

  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    logic [4:0] vs2;
    logic [4:0] vs1;
    logic [2:0] funct3;
    logic [4:0] vd;
    logic [6:0] opcode;
  } arith_fmt_t;

  typedef struct packed {
    logic [2:0] nf;
    logic       mew;
    logic [1:0] mop;
    logic       vm;
    logic [4:0] lumop;
    logic [4:0] rs1;
    width_t     width;
    logic [4:0] vd;
    logic [6:0] opcode;
  } mem_fmt_t;

  // one instruction word, read as OP-V or as load/store
  typedef union packed {
    arith_fmt_t arith;
    mem_fmt_t   mem;
  } vinstr_u;

  typedef enum logic [2:0] {
    VS2_NORMAL,
    VS2_IDX_PLUS_RS1,
    VS2_IDX_PLUS_UIMM,
    VS2_IDX_PLUS_1,
    VS2_IDX_MINUS_1,
    VS2_RS1,
    VS2_UIMM
  } vs2_src_t;

  typedef enum logic [1:0] {
    VD_NORMAL,
    VD_IDX_PLUS_RS1,
    VD_IDX_PLUS_UIMM
  } vd_src_t;

  typedef struct packed {
    logic                 is_load;
    logic                 is_store;
    logic                 is_arith;
    logic [4:0]           vd;
    logic [2:0]           nf;
    logic [3:0]           emul_regs;
    logic [`OFFSET_W-1:0] field_vl;
    sew_t                 eff_sew;
    vs2_src_t             vs2_src;
    vd_src_t              vd_src;
    logic [4:0]           imm5;
    logic [31:0]          xs1;
  } vctrl_t;

  typedef struct packed {
    logic                 valid;
    logic                 is_load;
    logic                 is_store;
    logic [4:0]           vd;
    logic [2:0]           field;
    sew_t                 eff_sew;
    logic [`OFFSET_W-1:0] woffset0;
    logic [`OFFSET_W-1:0] woffset1;
    logic [`OFFSET_W-1:0] vs2_offset0;
    logic [`OFFSET_W-1:0] vs2_offset1;
    logic [1:0]           wen;
    logic                 last;
  } dec_ex_t;

endpackage

//--- design/vector_ctrl_decode.sv
// purely combinational; any word that is not a vector load, store or OP-V leaves all kind flags low
`timescale 1ns/1ps
`include "vdec_consts.svh"

module vector_ctrl_decode (
  input  vdec_pkg::vinstr_u     instr,
  input  vdec_pkg::vtype_t      vtype,
  input  logic [`OFFSET_W-1:0]  vl,
  input  logic [31:0]           xs1,
  output vdec_pkg::vctrl_t      ctrl
);

  logic is_load, is_store, is_mem, is_arith, whole_reg, unit_stride;
  logic [2:0] funct3;
  logic [2:0] lmul_bits;
  logic [1:0] sew_bits, eew_bits;
  logic signed [3:0] eew_log, sew_log, lmul_log, emul_sum, emul_log;
  logic [`OFFSET_W-1:0] whole_vl;
  vdec_pkg::sew_t   eew;
  vdec_pkg::vlmul_t emul;

  assign is_load   = instr.mem.opcode == `OPC_VLOAD;
  assign is_store  = instr.mem.opcode == `OPC_VSTORE;
  assign is_mem    = is_load | is_store;
  assign is_arith  = instr.arith.opcode == `OPC_OPV;
  assign funct3    = instr.arith.funct3;

  assign unit_stride = instr.mem.mop == 2'b00;
  assign whole_reg   = is_mem & unit_stride & (instr.mem.lumop == `LUMOP_WHOLE);

  // VLENB/4 32-bit words per register, times the register count
  assign whole_vl = `OFFSET_W'((`VLENB / 4) * (instr.mem.nf + 1));

  always_comb begin
    case (instr.mem.width)
      vdec_pkg::WIDTH8:  eew = vdec_pkg::SEW8;
      vdec_pkg::WIDTH16: eew = vdec_pkg::SEW16;
      default:           eew = vdec_pkg::SEW32;
    endcase
    // arithmetic runs at SEW, so EMUL collapses to LMUL
    if (!is_mem) begin
      eew = vtype.sew;
    end
  end

  // EMUL = EEW/SEW * LMUL, done as a sum of logs
  assign sew_bits  = vtype.sew;
  assign eew_bits  = eew;
  assign lmul_bits = vtype.lmul;
  assign sew_log   = {2'b00, sew_bits};
  assign eew_log   = {2'b00, eew_bits};
  assign lmul_log  = {lmul_bits[2], lmul_bits};
  assign emul_sum  = eew_log - sew_log + lmul_log;

  always_comb begin
    if (emul_sum > 4'sd3) begin
      emul_log = 4'sd3;
    end else if (emul_sum < -4'sd2) begin
      emul_log = -4'sd2;
    end else begin
      emul_log = emul_sum;
    end
  end

  assign emul = vdec_pkg::vlmul_t'(emul_log[2:0]);

  always_comb begin
    ctrl          = '0;
    ctrl.is_load  = is_load;
    ctrl.is_store = is_store;
    ctrl.is_arith = is_arith;
    ctrl.vd       = is_mem ? instr.mem.vd : instr.arith.vd;
    ctrl.imm5     = instr.arith.vs1;
    ctrl.xs1      = xs1;
    ctrl.eff_sew  = eew;
    ctrl.vs2_src  = vdec_pkg::VS2_NORMAL;
    ctrl.vd_src   = vdec_pkg::VD_NORMAL;

    // whole-register moves are a single field
    if (is_mem && !whole_reg) begin
      ctrl.nf = instr.mem.nf;
    end

    case (emul)
      vdec_pkg::LMUL2: ctrl.emul_regs = 4'd2;
      vdec_pkg::LMUL4: ctrl.emul_regs = 4'd4;
      vdec_pkg::LMUL8: ctrl.emul_regs = 4'd8;
      default:         ctrl.emul_regs = 4'd1;
    endcase

    if (whole_reg) begin
      ctrl.field_vl = whole_vl;
    end else if (is_mem && instr.mem.nf != 3'd0) begin
      ctrl.field_vl = vl;
    end else if (is_mem && unit_stride && eew_bits < sew_bits) begin
      ctrl.field_vl = vl >> (sew_bits - eew_bits);
    end else begin
      ctrl.field_vl = vl;
    end

    if (is_arith) begin
      case (instr.arith.funct6)
        `F6_VSLIDEUP: begin
          if (funct3 == `F3_OPIVX) begin
            ctrl.vd_src = vdec_pkg::VD_IDX_PLUS_RS1;
          end else if (funct3 == `F3_OPIVI) begin
            ctrl.vd_src = vdec_pkg::VD_IDX_PLUS_UIMM;
          end else if (funct3 == `F3_OPMVX) begin
            // vslide1up
            ctrl.vs2_src = vdec_pkg::VS2_IDX_MINUS_1;
          end
        end
        `F6_VSLIDEDOWN: begin
          if (funct3 == `F3_OPIVX) begin
            ctrl.vs2_src = vdec_pkg::VS2_IDX_PLUS_RS1;
          end else if (funct3 == `F3_OPIVI) begin
            ctrl.vs2_src = vdec_pkg::VS2_IDX_PLUS_UIMM;
          end else if (funct3 == `F3_OPMVX) begin
            // vslide1down
            ctrl.vs2_src = vdec_pkg::VS2_IDX_PLUS_1;
          end
        end
        `F6_VRGATHER: begin
          if (funct3 == `F3_OPIVX) begin
            ctrl.vs2_src = vdec_pkg::VS2_RS1;
          end else if (funct3 == `F3_OPIVI) begin
            ctrl.vs2_src = vdec_pkg::VS2_UIMM;
          end
        end
        default: begin
          // vadd walks vd and vs2 together on the element index
          ctrl.vs2_src = vdec_pkg::VS2_NORMAL;
        end
      endcase
    end
  end

endmodule

//--- design/vector_decode_stage.sv
// no handshake on instr; a strobe is taken only while busy is low, otherwise it is dropped
`timescale 1ns/1ps
`include "vdec_consts.svh"

module vector_decode_stage (
  input  logic                  CLK,
  input  logic                  nRST,
  input  vdec_pkg::vinstr_u     instr,
  input  logic                  instr_valid,
  input  vdec_pkg::vtype_t      vtype,
  input  logic [`OFFSET_W-1:0]  vl,
  input  logic [`OFFSET_W-1:0]  vstart,
  input  logic [31:0]           xs1,
  input  logic                  stall,
  input  logic                  flush,
  output logic                  busy,
  output vdec_pkg::dec_ex_t     dec_ex
);

  vdec_pkg::vctrl_t dec_ctrl, cur_ctrl;
  logic [4:0] cur_vd;
  logic [2:0] field;
  logic accept, field_done;

  assign accept = instr_valid & ~busy;

  vector_ctrl_decode ctrl_i (
    .instr (instr),
    .vtype (vtype),
    .vl    (vl),
    .xs1   (xs1),
    .ctrl  (dec_ctrl)
  );

  // busy is the buffer's occupied flag
  segment_field_buffer buf_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .accept     (accept),
    .flush      (flush),
    .stall      (stall),
    .field_done (field_done),
    .ctrl       (dec_ctrl),
    .cur_ctrl   (cur_ctrl),
    .cur_vd     (cur_vd),
    .field      (field),
    .occupied   (busy)
  );

  element_issue issue_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .occupied   (busy),
    .stall      (stall),
    .flush      (flush),
    .cur_ctrl   (cur_ctrl),
    .cur_vd     (cur_vd),
    .field      (field),
    .vstart     (vstart),
    .vl         (vl),
    .field_done (field_done),
    .dec_ex     (dec_ex)
  );

endmodule

//--- project.f
+incdir+design
design/vdec_pkg.sv
design/vector_ctrl_decode.sv
design/segment_field_buffer.sv
design/element_issue.sv
design/vector_decode_stage.sv
test/vector_decode_stage_assert.sv
test/vector_decode_stage_tb.sv

//--- test/vector_decode_stage_assert.sv
// sees only the top-level ports, so internal counters are not covered here
`timescale 1ns/1ps

module vector_decode_stage_assert (
  input logic               CLK,
  input logic               nRST,
  input logic               instr_valid,
  input logic               stall,
  input logic               flush,
  input logic               busy,
  input vdec_pkg::dec_ex_t  dec_ex
);

  // record and enables stay clear under reset
  reset_quiet: assert property (@(posedge CLK) !nRST |-> !dec_ex.valid && dec_ex.wen == 2'b00)
    else $error("dec_ex valid or wen set while reset is active");

  hold_on_stall: assert property (@(posedge CLK) disable iff (!nRST)
    stall && !flush |=> $stable(dec_ex))
    else $error("dec_ex changed during a stall");

  flush_clears: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !dec_ex.valid)
    else $error("dec_ex.valid still high after a flush");

  // busy only rises out of an accept cycle
  busy_from_accept: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(busy) |-> $past(instr_valid && !busy))
    else $error("busy rose without an accepted instruction");

endmodule

bind vector_decode_stage vector_decode_stage_assert assert_i (.*);

//--- test/vector_decode_stage_tb.sv
// rows run back to back with vl and vstart held per row; random stalls start from seed 88
`timescale 1ns/1ps
`include "vdec_consts.svh"

module vector_decode_stage_tb;

  localparam int NROWS = 13;

  typedef struct {
    logic [31:0] instr;
    logic [4:0]  vtype;
    logic [7:0]  vl;
    logic [7:0]  vstart;
    logic [31:0] xs1;
    logic        rand_stall;
    int          flush_at;
    int          pairs;
    int          fields;
    logic [4:0]  vd0;
    logic [4:0]  vd_step;
    logic [7:0]  w0;
    logic [7:0]  vs2_0;
    logic        gap;
    logic [1:0]  wen_mid;
    logic [1:0]  wen_end;
    logic [1:0]  sew;
  } row_t;

  logic CLK, nRST, instr_valid, stall, flush, busy, table_ready;
  vdec_pkg::vinstr_u instr;
  vdec_pkg::vtype_t  vtype;
  vdec_pkg::dec_ex_t dec_ex;
  logic [7:0] vl, vstart;
  logic [31:0] xs1;
  row_t rows [NROWS];
  integer seed;
  int checks, errors;

  vector_decode_stage dut_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr       (instr),
    .instr_valid (instr_valid),
    .vtype       (vtype),
    .vl          (vl),
    .vstart      (vstart),
    .xs1         (xs1),
    .stall       (stall),
    .flush       (flush),
    .busy        (busy),
    .dec_ex      (dec_ex)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // vs2 field is fixed at v8, vm set
  function automatic logic [31:0] opv_word(input logic [5:0] f6, input logic [2:0] f3,
                                           input logic [4:0] vs1, input logic [4:0] vd);
    opv_word = {f6, 1'b1, 5'd8, vs1, f3, vd, `OPC_OPV};
  endfunction

  // unit-stride, rs1 = x10
  function automatic logic [31:0] mem_word(input logic [2:0] nf, input logic [4:0] lumop,
                                           input logic [2:0] width, input logic [4:0] vd,
                                           input logic [6:0] opc);
    mem_word = {nf, 1'b0, 2'b00, 1'b1, lumop, 5'd10, width, vd, opc};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // columns: instr, vtype, vl, vstart, xs1, stall, flush_at, pairs, fields,
  // vd0, vd_step, first woffset, first vs2 offset, lane gap, wen mid, wen end, sew
  task automatic load_table();
    rows[0]  = '{opv_word(`F6_VADD, `F3_OPIVV, 5'd12, 5'd4), {vdec_pkg::SEW32, vdec_pkg::LMUL1},
                 8'd7, 8'd0, 32'd0, 1'b0, 0, 4, 1, 5'd4, 5'd0, 8'd0, 8'd0, 1'b1, 2'b11, 2'b01, 2'b10};
    rows[1]  = '{opv_word(`F6_VSLIDEDOWN, `F3_OPIVX, 5'd1, 5'd6), {vdec_pkg::SEW16, vdec_pkg::LMUL1},
                 8'd8, 8'd0, 32'd5, 1'b1, 0, 4, 1, 5'd6, 5'd0, 8'd0, 8'd5, 1'b1, 2'b11, 2'b11, 2'b01};
    rows[2]  = '{opv_word(`F6_VSLIDEUP, `F3_OPIVI, 5'd3, 5'd1), {vdec_pkg::SEW8, vdec_pkg::LMUL1},
                 8'd6, 8'd0, 32'd0, 1'b0, 0, 3, 1, 5'd1, 5'd0, 8'd3, 8'd0, 1'b1, 2'b11, 2'b11, 2'b00};
    rows[3]  = '{opv_word(`F6_VSLIDEUP, `F3_OPMVX, 5'd1, 5'd2), {vdec_pkg::SEW32, vdec_pkg::LMUL1},
                 8'd4, 8'd0, 32'd0, 1'b0, 0, 2, 1, 5'd2, 5'd0, 8'd0, 8'hff, 1'b1, 2'b11, 2'b11, 2'b10};
    rows[4]  = '{opv_word(`F6_VSLIDEDOWN, `F3_OPMVX, 5'd1, 5'd3), {vdec_pkg::SEW32, vdec_pkg::LMUL1},
                 8'd5, 8'd0, 32'd0, 1'b0, 0, 3, 1, 5'd3, 5'd0, 8'd0, 8'd1, 1'b1, 2'b11, 2'b01, 2'b10};
    rows[5]  = '{opv_word(`F6_VRGATHER, `F3_OPIVX, 5'd1, 5'd5), {vdec_pkg::SEW32, vdec_pkg::LMUL1},
                 8'd4, 8'd0, 32'd9, 1'b0, 0, 2, 1, 5'd5, 5'd0, 8'd0, 8'd9, 1'b0, 2'b11, 2'b11, 2'b10};
    // EEW 8 under SEW 32 issues a quarter of vl
    rows[6]  = '{mem_word(3'd0, 5'd0, 3'b000, 5'd2, `OPC_VLOAD), {vdec_pkg::SEW32, vdec_pkg::LMUL1},
                 8'd16, 8'd0, 32'd0, 1'b0, 0, 2, 1, 5'd2, 5'd0, 8'd0, 8'd0, 1'b1, 2'b11, 2'b11, 2'b00};
    rows[7]  = '{mem_word(3'd0, 5'd0, 3'b110, 5'd7, `OPC_VSTORE), {vdec_pkg::SEW32, vdec_pkg::LMUL1},
                 8'd6, 8'd0, 32'd0, 1'b1, 0, 3, 1, 5'd7, 5'd0, 8'd0, 8'd0, 1'b1, 2'b00, 2'b00, 2'b10};
    rows[8]  = '{mem_word(3'd0, 5'd0, 3'b110, 5'd3, `OPC_VLOAD), {vdec_pkg::SEW32, vdec_pkg::LMUL1},
                 8'd4, 8'd4, 32'd0, 1'b0, 0, 2, 1, 5'd3, 5'd0, 8'd0, 8'd0, 1'b1, 2'b00, 2'b00, 2'b10};
    // three fields, each two registers apart
    rows[9]  = '{mem_word(3'd2, 5'd0, 3'b101, 5'd8, `OPC_VLOAD), {vdec_pkg::SEW16, vdec_pkg::LMUL2},
                 8'd5, 8'd0, 32'd0, 1'b1, 0, 3, 3, 5'd8, 5'd2, 8'd0, 8'd0, 1'b1, 2'b11, 2'b01, 2'b01};
    rows[10] = '{mem_word(3'd1, `LUMOP_WHOLE, 3'b110, 5'd16, `OPC_VLOAD),
                 {vdec_pkg::SEW8, vdec_pkg::LMUL1},
                 8'd3, 8'd0, 32'd0, 1'b0, 0, 4, 1, 5'd16, 5'd0, 8'd0, 8'd0, 1'b1, 2'b11, 2'b11, 2'b10};
    rows[11] = '{opv_word(`F6_VADD, `F3_OPIVX, 5'd1, 5'd4), {vdec_pkg::SEW32, vdec_pkg::LMUL1},
                 8'd20, 8'd0, 32'd0, 1'b0, 3, 10, 1, 5'd4, 5'd0, 8'd0, 8'd0, 1'b1, 2'b11, 2'b11, 2'b10};
    rows[12] = '{opv_word(`F6_VADD, `F3_OPIVI, 5'd2, 5'd9), {vdec_pkg::SEW32, vdec_pkg::LMUL1},
                 8'd3, 8'd0, 32'd0, 1'b0, 0, 2, 1, 5'd9, 5'd0, 8'd0, 8'd0, 1'b1, 2'b11, 2'b01, 2'b10};
  endtask

  // n counts valid records of the row, field by field
  task automatic check_record(input int r, input int n);
    int fld, k;
    logic [7:0] w, v;
    logic [4:0] vd_exp;
    fld = n / rows[r].pairs;
    k = n % rows[r].pairs;
    w = rows[r].w0 + 8'(2 * k);
    v = rows[r].vs2_0 + (rows[r].gap ? 8'(2 * k) : 8'd0);
    vd_exp = rows[r].vd0 + 5'(fld) * rows[r].vd_step;
    // the kind flags follow the major opcode of the row's word
    check_value("dec_ex.is_load", dec_ex.is_load, rows[r].instr[6:0] == `OPC_VLOAD);
    check_value("dec_ex.is_store", dec_ex.is_store, rows[r].instr[6:0] == `OPC_VSTORE);
    check_value("dec_ex.field", dec_ex.field, fld);
    check_value("dec_ex.vd", dec_ex.vd, vd_exp);
    check_value("dec_ex.eff_sew", dec_ex.eff_sew, rows[r].sew);
    check_value("dec_ex.woffset0", dec_ex.woffset0, w);
    check_value("dec_ex.woffset1", dec_ex.woffset1, 8'(w + 8'd1));
    check_value("dec_ex.vs2_offset0", dec_ex.vs2_offset0, v);
    check_value("dec_ex.vs2_offset1", dec_ex.vs2_offset1, 8'(v + 8'(rows[r].gap)));
    check_value("dec_ex.wen", dec_ex.wen,
                (k == rows[r].pairs - 1) ? rows[r].wen_end : rows[r].wen_mid);
    check_value("dec_ex.last", dec_ex.last, n == rows[r].pairs * rows[r].fields - 1);
  endtask

  task automatic run_row(input int r);
    int got;
    logic stall_prev, done;
    got = 0;
    done = 1'b0;
    @(posedge CLK);
    instr <= rows[r].instr;
    vtype <= rows[r].vtype;
    vl <= rows[r].vl;
    vstart <= rows[r].vstart;
    xs1 <= rows[r].xs1;
    instr_valid <= 1'b1;
    stall <= 1'b0;
    @(posedge CLK);
    instr_valid <= 1'b0;
    @(negedge CLK);
    stall_prev = stall;
    while (!done) begin
      @(posedge CLK);
      stall <= rows[r].rand_stall && ($random(seed) % 2 != 0);
      @(negedge CLK);
      // a held record under stall is not a new one
      if (dec_ex.valid && !stall_prev) begin
        check_record(r, got);
        got++;
      end
      stall_prev = stall;
      if (rows[r].flush_at != 0 && got == rows[r].flush_at) begin
        @(posedge CLK);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        @(negedge CLK);
        check_value("dec_ex.valid", dec_ex.valid, 0);
        check_value("busy", busy, 0);
        done = 1'b1;
      end else if (!busy) begin
        done = 1'b1;
      end
    end
    if (rows[r].flush_at == 0) begin
      check_value("record count", got, rows[r].pairs * rows[r].fields);
    end
  endtask

  // limit grows with the pairs in the table
  initial begin : watchdog
    int total, limit;
    wait (table_ready);
    total = 0;
    foreach (rows[i]) total += rows[i].pairs * rows[i].fields;
    limit = 4 * total + 10 * NROWS + 30;
    repeat (limit) @(posedge CLK);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("Something failed");
    $finish;
  end

  initial begin
    nRST = 1'b0;
    instr = '0;
    instr_valid = 1'b0;
    vtype = '0;
    vl = '0;
    vstart = '0;
    xs1 = '0;
    stall = 1'b0;
    flush = 1'b0;
    table_ready = 1'b0;
    seed = 88;
    checks = 0;
    errors = 0;
    load_table();
    table_ready = 1'b1;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    check_value("busy", busy, 0);
    check_value("dec_ex.valid", dec_ex.valid, 0);
    check_value("dec_ex.wen", dec_ex.wen, 0);
    check_value("dec_ex.last", dec_ex.last, 0);
    @(posedge CLK);
    nRST <= 1'b1;
    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
    end
    repeat (2) @(posedge CLK);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
